/* include/matrix_defines.svh */
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

// panel geometry.
`define PIXEL_WIDTH 16
`define PIXEL_HEIGHT 8
`define BYTES_PER_PIXEL 3

// address field widths, derived from the geometry.
`define COL_BITS ($clog2(`PIXEL_WIDTH))
`define ROW_BITS ($clog2(`PIXEL_HEIGHT))
`define PIX_BITS ($clog2(`BYTES_PER_PIXEL))

// framebuffer size in bytes and the width of a flat byte index.
`define FB_DEPTH (`PIXEL_WIDTH * `PIXEL_HEIGHT * `BYTES_PER_PIXEL)
`define FB_ADDR_BITS ($clog2(`FB_DEPTH))

`endif

/* sim.f */
+incdir+include
src/matrix_pkg.sv
src/cmd_decoder.sv
src/cmd_readrow.sv
src/cmd_fill.sv
src/framebuffer.sv
src/led_matrix_top.sv
verif/led_matrix_properties.sv
verif/led_matrix_tb.sv

/* src/cmd_decoder.sv */
`timescale 1ns/1ns

module cmd_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [7:0]            in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic                  rr_start,
    output logic                  rr_byte_en,
    output logic                  fill_start,
    output logic                  fill_byte_en,
    output logic [7:0]            byte_data,
    input  logic                  rr_done,
    input  logic                  fill_done,
    input  logic                  fill_busy,
    input  matrix_pkg::fb_write_t rr_wr,
    input  matrix_pkg::fb_write_t fill_wr,
    output matrix_pkg::fb_write_t fb_wr,
    output logic                  cmd_done,
    output logic                  bad_cmd
);
    matrix_pkg::dec_state_t state;
    logic take;
    logic op_readrow;
    logic op_fill;

    assign take       = in_valid && in_ready;
    assign op_readrow = in_data == matrix_pkg::OP_READROW;
    assign op_fill    = in_data == matrix_pkg::OP_FILL;

    // ready drops while a handler finishes or the fill sweep runs.
    always_comb begin
        case (state)
            matrix_pkg::ST_OPCODE:  in_ready = 1'b1;
            matrix_pkg::ST_READROW: in_ready = !rr_done;
            matrix_pkg::ST_FILL:    in_ready = !fill_busy;
            default:                in_ready = 1'b0;
        endcase
    end

    assign rr_start     = state == matrix_pkg::ST_OPCODE && take && op_readrow;
    assign fill_start   = state == matrix_pkg::ST_OPCODE && take && op_fill;
    assign rr_byte_en   = state == matrix_pkg::ST_READROW && take;
    assign fill_byte_en = state == matrix_pkg::ST_FILL && take;
    assign byte_data    = in_data;

    assign cmd_done = rr_done || fill_done;

    // only the active handler reaches the RAM.
    always_comb begin
        case (state)
            matrix_pkg::ST_READROW: fb_wr = rr_wr;
            matrix_pkg::ST_FILL:    fb_wr = fill_wr;
            default:                fb_wr = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= matrix_pkg::ST_OPCODE;
            bad_cmd <= 1'b0;
        end else begin
            bad_cmd <= 1'b0;
            case (state)
                matrix_pkg::ST_OPCODE: begin
                    if (take) begin
                        if (op_readrow) begin
                            state <= matrix_pkg::ST_READROW;
                        end else if (op_fill) begin
                            state <= matrix_pkg::ST_FILL;
                        end else begin
                            bad_cmd <= 1'b1; // unknown opcode is dropped.
                        end
                    end
                end
                matrix_pkg::ST_READROW: begin
                    if (rr_done) begin
                        state <= matrix_pkg::ST_DONE;
                    end
                end
                matrix_pkg::ST_FILL: begin
                    if (fill_done) begin
                        state <= matrix_pkg::ST_DONE;
                    end
                end
                default: begin
                    state <= matrix_pkg::ST_OPCODE; // one idle cycle after a command.
                end
            endcase
        end
    end

endmodule

/* src/cmd_fill.sv */
`timescale 1ns/1ns
`include "matrix_defines.svh"

module cmd_fill (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  byte_en,
    input  logic [7:0]            byte_data,
    output matrix_pkg::fb_write_t wr,
    output logic                  busy,
    output logic                  done
);
    localparam int ROW_W = `ROW_BITS;
    localparam int COL_W = `COL_BITS;
    localparam int PIX_W = `PIX_BITS;
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`PIXEL_HEIGHT - 1);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`PIXEL_WIDTH - 1);
    localparam logic [PIX_W-1:0] LAST_PIX = PIX_W'(`BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        FL_IDLE,
        FL_COLOUR,
        FL_SWEEP
    } fill_state_t;

    fill_state_t state;
    logic [7:0] colour [`BYTES_PER_PIXEL];
    logic [PIX_W-1:0] colour_idx;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] column;
    logic [PIX_W-1:0] pixel;
    logic last_pos;

    assign last_pos = row == LAST_ROW && column == LAST_COL && pixel == LAST_PIX;
    assign busy     = state == FL_SWEEP;
    assign done     = busy && last_pos;

    assign wr.strobe      = busy;
    assign wr.addr.row    = row;
    assign wr.addr.column = column;
    assign wr.addr.pixel  = pixel;
    assign wr.data        = colour[pixel];

    // first colour byte lands on the highest pixel index.
    always_ff @(posedge clk) begin
        if (state == FL_COLOUR && byte_en) begin
            colour[colour_idx] <= byte_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= FL_IDLE;
            colour_idx <= LAST_PIX;
            row        <= '0;
            column     <= '0;
            pixel      <= '0;
        end else if (start) begin
            state      <= FL_COLOUR;
            colour_idx <= LAST_PIX;
        end else if (state == FL_COLOUR) begin
            if (byte_en) begin
                colour_idx <= colour_idx - 1'b1;
                if (colour_idx == '0) begin
                    state  <= FL_SWEEP;
                    row    <= '0;
                    column <= '0;
                    pixel  <= '0;
                end
            end
        end else if (state == FL_SWEEP) begin
            if (last_pos) begin
                state <= FL_IDLE;
            end else if (pixel != LAST_PIX) begin
                pixel <= pixel + 1'b1;
            end else begin
                pixel <= '0;
                if (column != LAST_COL) begin
                    column <= column + 1'b1;
                end else begin
                    column <= '0;
                    row    <= row + 1'b1; // next panel row.
                end
            end
        end
    end

endmodule

/* src/cmd_readrow.sv */
`timescale 1ns/1ns
`include "matrix_defines.svh"

module cmd_readrow (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  byte_en,
    input  logic [7:0]            byte_data,
    output matrix_pkg::fb_write_t wr,
    output logic                  done
);
    localparam int ROW_W = `ROW_BITS;
    localparam int COL_W = `COL_BITS;
    localparam int PIX_W = `PIX_BITS;
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`PIXEL_WIDTH - 1);
    localparam logic [PIX_W-1:0] LAST_PIX = PIX_W'(`BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        RR_ROW,
        RR_CONTENT,
        RR_DONE
    } rr_state_t;

    rr_state_t state;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] column;
    logic [PIX_W-1:0] pixel;
    logic last_pos;

    assign last_pos = column == '0 && pixel == '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= RR_ROW;
            row    <= '0;
            column <= LAST_COL;
            pixel  <= LAST_PIX;
            wr     <= '0;
            done   <= 1'b0;
        end else begin
            wr.strobe <= 1'b0;
            done      <= 1'b0;
            if (start) begin
                state  <= RR_ROW;
                column <= LAST_COL;
                pixel  <= LAST_PIX;
            end else begin
                case (state)
                    RR_ROW: begin
                        if (byte_en) begin
                            row   <= byte_data[ROW_W-1:0]; // high bits ignored.
                            state <= RR_CONTENT;
                        end
                    end
                    RR_CONTENT: begin
                        if (byte_en) begin
                            wr.strobe      <= 1'b1;
                            wr.addr.row    <= row;
                            wr.addr.column <= column;
                            wr.addr.pixel  <= pixel;
                            wr.data        <= byte_data;
                            if (last_pos) begin
                                done  <= 1'b1;
                                state <= RR_DONE;
                            end else if (pixel == '0) begin
                                pixel  <= LAST_PIX;
                                column <= column - 1'b1;
                            end else begin
                                pixel <= pixel - 1'b1;
                            end
                        end
                    end
                    default: begin
                        // rearm for the next row.
                        state  <= RR_ROW;
                        column <= LAST_COL;
                        pixel  <= LAST_PIX;
                    end
                endcase
            end
        end
    end

endmodule

/* src/framebuffer.sv */
`timescale 1ns/1ns
`include "matrix_defines.svh"

module framebuffer (
    input  logic                  clk,
    input  matrix_pkg::fb_write_t wr,
    input  matrix_pkg::fb_addr_t  rd_addr,
    output logic [7:0]            rd_data
);
    localparam int ADDR_W = `FB_ADDR_BITS;

    logic [7:0] mem [`FB_DEPTH];
    logic [ADDR_W-1:0] wr_index;
    logic [ADDR_W-1:0] rd_index;

    // flat byte position of a row, column and pixel.
    function automatic logic [ADDR_W-1:0] byte_index(input matrix_pkg::fb_addr_t a);
        int flat;
        flat = (int'(a.row) * `PIXEL_WIDTH + int'(a.column)) * `BYTES_PER_PIXEL
               + int'(a.pixel);
        return ADDR_W'(flat);
    endfunction

    assign wr_index = byte_index(wr.addr);
    assign rd_index = byte_index(rd_addr);

    // same cycle read of a written address returns the old byte.
    always_ff @(posedge clk) begin
        if (wr.strobe) begin
            mem[wr_index] <= wr.data;
        end
        rd_data <= mem[rd_index];
    end

endmodule

/* src/led_matrix_top.sv */
`timescale 1ns/1ns

module led_matrix_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  matrix_pkg::fb_addr_t rd_addr,
    output logic [7:0]           rd_data,
    output logic                 cmd_done,
    output logic                 bad_cmd
);
    logic rr_start;
    logic rr_byte_en;
    logic fill_start;
    logic fill_byte_en;
    logic [7:0] byte_data;
    logic rr_done;
    logic fill_done;
    logic fill_busy;
    matrix_pkg::fb_write_t rr_wr;
    matrix_pkg::fb_write_t fill_wr;
    matrix_pkg::fb_write_t fb_wr;

    cmd_decoder cmd_decoder_i (
        .clk          (clk),
        .reset        (reset),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .rr_start     (rr_start),
        .rr_byte_en   (rr_byte_en),
        .fill_start   (fill_start),
        .fill_byte_en (fill_byte_en),
        .byte_data    (byte_data),
        .rr_done      (rr_done),
        .fill_done    (fill_done),
        .fill_busy    (fill_busy),
        .rr_wr        (rr_wr),
        .fill_wr      (fill_wr),
        .fb_wr        (fb_wr),
        .cmd_done     (cmd_done),
        .bad_cmd      (bad_cmd)
    );

    cmd_readrow cmd_readrow_i (
        .clk       (clk),
        .reset     (reset),
        .start     (rr_start),
        .byte_en   (rr_byte_en),
        .byte_data (byte_data),
        .wr        (rr_wr),
        .done      (rr_done)
    );

    cmd_fill cmd_fill_i (
        .clk       (clk),
        .reset     (reset),
        .start     (fill_start),
        .byte_en   (fill_byte_en),
        .byte_data (byte_data),
        .wr        (fill_wr),
        .busy      (fill_busy),
        .done      (fill_done)
    );

    framebuffer framebuffer_i (
        .clk     (clk),
        .wr      (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* src/matrix_pkg.sv */
`include "matrix_defines.svh"

package matrix_pkg;

    // command opcode byte values.
    typedef enum logic [7:0] {
        OP_READROW = 8'h01,
        OP_FILL    = 8'h02
    } cmd_opcode_t;

    // decoder FSM states.
    typedef enum logic [1:0] {
        ST_OPCODE,
        ST_READROW,
        ST_FILL,
        ST_DONE
    } dec_state_t;

    // location of one framebuffer byte.
    typedef struct packed {
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] column;
        logic [`PIX_BITS-1:0] pixel;
    } fb_addr_t;

    // one framebuffer write.
    typedef struct packed {
        logic       strobe;
        fb_addr_t   addr;
        logic [7:0] data;
    } fb_write_t;

endpackage

/* verif/led_matrix_properties.sv */
`timescale 1ns/1ns

module led_matrix_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  in_ready,
    input logic                  cmd_done,
    input logic                  bad_cmd,
    input matrix_pkg::fb_write_t fb_wr,
    input matrix_pkg::fb_write_t rr_wr,
    input matrix_pkg::fb_write_t fill_wr
);
    int failures = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (reset) cmd_done |=> !cmd_done)
        else begin
            $error("cmd_done high for two cycles");
            failures++;
        end

    bad_one_cycle: assert property (@(posedge clk) disable iff (reset) bad_cmd |=> !bad_cmd)
        else begin
            $error("bad_cmd high for two cycles");
            failures++;
        end

    // decoder sits in its done state here.
    ready_low_after_done: assert property (@(posedge clk) disable iff (reset)
            cmd_done |=> !in_ready)
        else begin
            $error("in_ready high in the cycle after cmd_done");
            failures++;
        end

    no_write_in_reset: assert property (@(posedge clk)
            reset |-> !(fb_wr.strobe || rr_wr.strobe || fill_wr.strobe))
        else begin
            $error("write strobe active during reset");
            failures++;
        end

endmodule

bind led_matrix_top led_matrix_properties led_matrix_properties_i (
    .clk      (clk),
    .reset    (reset),
    .in_ready (in_ready),
    .cmd_done (cmd_done),
    .bad_cmd  (bad_cmd),
    .fb_wr    (fb_wr),
    .rr_wr    (rr_wr),
    .fill_wr  (fill_wr)
);

/* verif/led_matrix_tb.sv */
`timescale 1ns/1ns
`include "matrix_defines.svh"

module led_matrix_tb;
    localparam int WIDTH      = `PIXEL_WIDTH;
    localparam int HEIGHT     = `PIXEL_HEIGHT;
    localparam int BPP        = `BYTES_PER_PIXEL;
    localparam int DEPTH      = `FB_DEPTH;
    localparam int ROW_W      = `ROW_BITS;
    localparam int COL_W      = `COL_BITS;
    localparam int PIX_W      = `PIX_BITS;
    localparam int NUM_CMDS   = 8;
    localparam int WAIT_LIMIT = 1000;

    typedef struct packed {
        logic [7:0]       opcode;
        logic [7:0]       row_byte;
        logic [23:0]      colour;   // byte 2 is sent first.
        logic             gap;
        logic [ROW_W-1:0] exp_row;
        logic             exp_done;
        logic             exp_bad;
        logic [15:0]      exp_wait; // cycles from last byte to cmd_done or bad_cmd.
    } cmd_entry_t;

    logic clk;
    logic reset;
    logic [7:0] in_data;
    logic in_valid;
    logic in_ready;
    matrix_pkg::fb_addr_t rd_addr;
    logic [7:0] rd_data;
    logic cmd_done;
    logic bad_cmd;

    logic [7:0] model [DEPTH];
    logic [31:0] rng_state;
    int done_count = 0;
    int bad_count = 0;

    cmd_entry_t cmd_table [NUM_CMDS] = '{
        '{8'h02, 8'h00, 24'h3ca50f, 1'b0, 3'd0, 1'b1, 1'b0, 16'd383},
        '{8'h01, 8'h05, 24'h000000, 1'b0, 3'd5, 1'b1, 1'b0, 16'd0},
        '{8'h01, 8'hfa, 24'h000000, 1'b0, 3'd2, 1'b1, 1'b0, 16'd0},
        '{8'h7e, 8'h00, 24'h000000, 1'b0, 3'd0, 1'b0, 1'b1, 16'd0},
        '{8'h01, 8'h01, 24'h000000, 1'b1, 3'd1, 1'b1, 1'b0, 16'd0},
        '{8'hff, 8'h00, 24'h000000, 1'b0, 3'd0, 1'b0, 1'b1, 16'd0},
        '{8'h02, 8'h00, 24'h102030, 1'b1, 3'd0, 1'b1, 1'b0, 16'd383},
        '{8'h01, 8'h87, 24'h000000, 1'b1, 3'd7, 1'b1, 1'b0, 16'd0}
    };

    led_matrix_top led_matrix_top_i (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .cmd_done (cmd_done),
        .bad_cmd  (bad_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // pulse counters, sampled mid cycle.
    always @(negedge clk) begin
        if (!reset && cmd_done) done_count++;
        if (!reset && bad_cmd) bad_count++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int model_index(input int row, input int col, input int pix);
        return (row * WIDTH + col) * BPP + pix;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $fatal(1, "wait limit reached");
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // returns one ns after the edge that took the byte.
    task automatic send_byte(input logic [7:0] value);
        int waited;
        waited = 0;
        in_data = value;
        in_valid = 1'b1;
        while (!in_ready) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) timeout_fail("in_ready");
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (!cmd_done) begin
            check_value(32'(in_ready), 32'd0, "in_ready low while a command writes");
            next_cycle();
            cycles++;
            if (cycles > WAIT_LIMIT) timeout_fail("cmd_done");
        end
    endtask

    task automatic wait_bad(output int cycles);
        cycles = 0;
        while (!bad_cmd) begin
            next_cycle();
            cycles++;
            if (cycles > WAIT_LIMIT) timeout_fail("bad_cmd");
        end
    endtask

    task automatic send_fill(input cmd_entry_t entry);
        logic [7:0] value;
        for (int p = BPP - 1; p >= 0; p--) begin
            value = entry.colour[8*p +: 8];
            if (entry.gap) idle_cycles(2);
            send_byte(value);
        end
        for (int idx = 0; idx < DEPTH; idx++) begin
            model[idx] = entry.colour[8*(idx % BPP) +: 8]; // pixel is index mod bpp.
        end
    endtask

    task automatic send_readrow(input cmd_entry_t entry);
        int col;
        int pix;
        logic [7:0] value;
        if (entry.gap) idle_cycles(2);
        send_byte(entry.row_byte);
        for (int k = 0; k < WIDTH * BPP; k++) begin
            rng_state = xorshift32(rng_state);
            value = rng_state[7:0];
            col = WIDTH - 1 - k / BPP;
            pix = BPP - 1 - k % BPP;
            model[model_index(int'(entry.exp_row), col, pix)] = value;
            if (entry.gap) idle_cycles(2);
            send_byte(value);
        end
    endtask

    task automatic check_framebuffer;
        for (int r = 0; r < HEIGHT; r++) begin
            for (int c = 0; c < WIDTH; c++) begin
                for (int p = 0; p < BPP; p++) begin
                    rd_addr.row = ROW_W'(r);
                    rd_addr.column = COL_W'(c);
                    rd_addr.pixel = PIX_W'(p);
                    next_cycle();
                    check_value(32'(rd_data), 32'(model[model_index(r, c, p)]),
                                $sformatf("byte at row %0d column %0d pixel %0d", r, c, p));
                end
            end
        end
    endtask

    initial begin
        cmd_entry_t entry;
        int cycles;
        int done_before;
        int bad_before;
        reset = 1'b1;
        in_data = 8'h00;
        in_valid = 1'b0;
        rd_addr = '0;
        rng_state = 32'hf9fd;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value(32'(in_ready), 32'd1, "in_ready after reset");
        check_value(32'(cmd_done), 32'd0, "cmd_done after reset");
        check_value(32'(bad_cmd), 32'd0, "bad_cmd after reset");

        for (int i = 0; i < NUM_CMDS; i++) begin
            entry = cmd_table[i];
            done_before = done_count;
            bad_before = bad_count;
            send_byte(entry.opcode);
            if (entry.opcode == matrix_pkg::OP_FILL) begin
                send_fill(entry);
            end else if (entry.opcode == matrix_pkg::OP_READROW) begin
                send_readrow(entry);
            end
            if (entry.exp_done) begin
                wait_done(cycles);
                check_value(32'(cycles), 32'(entry.exp_wait), "cycles until cmd_done");
                next_cycle();
                check_value(32'(in_ready), 32'd0, "in_ready in the idle cycle after a command");
            end
            if (entry.exp_bad) begin
                wait_bad(cycles);
                check_value(32'(cycles), 32'(entry.exp_wait), "cycles until bad_cmd");
                next_cycle();
            end
            check_framebuffer();
            check_value(32'(done_count - done_before), 32'(entry.exp_done),
                        $sformatf("cmd_done pulses for command %0d", i));
            check_value(32'(bad_count - bad_before), 32'(entry.exp_bad),
                        $sformatf("bad_cmd pulses for command %0d", i));
        end

        if (led_matrix_top_i.led_matrix_properties_i.failures == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "assertion failures in the bound checker");
        end
    end

endmodule
